// File: source/cmd_decoder.sv
////////////////////////////////////////////////////////////////////////////
// command decoder
// holds vertex and color state, launches raster jobs and
// exchanges the front and back framebuffers
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "tri_raster_defines.svh"

module cmd_decoder
    import gfx_cmd_pkg::*, gfx_pixel_pkg::*;
(
    input  logic        clk,
    input  logic        reset_i,
    input  logic        cmd_valid_i,
    input  logic [31:0] cmd_data_i,
    output logic        cmd_ready_o,
    input  logic        vsync_i,
    output logic        swap_o,
    output vram_addr_t  front_addr_o,
    output logic        job_start_o,
    output raster_job_t job_o,
    input  logic        job_done_i
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_RASTER,
        ST_SWAP
    } dec_state_t;

    dec_state_t    state;
    vertex_t [2:0] vtx;
    color_t        fill_color;
    vram_addr_t    back_addr;
    opcode_t       op;
    coord_t        cmd_coord;
    color_t        cmd_color;
    logic          cmd_accept;
    logic          do_swap;

    assign op         = opcode_t'(cmd_data_i[31:24]);
    assign cmd_coord  = coord_t'(cmd_data_i[11:0]);
    assign cmd_color  = color_t'(cmd_data_i[15:0]);
    assign cmd_ready_o = (state == ST_IDLE);
    assign cmd_accept = cmd_valid_i && cmd_ready_o;

    // bit 0 of a swap asks to wait for vsync
    assign do_swap = (cmd_accept && op == OP_SWAP && !cmd_data_i[0]) ||
                     (state == ST_SWAP && !swap_o && vsync_i);

    always_ff @(posedge clk) begin
        job_start_o <= 1'b0;
        swap_o      <= 1'b0;

        case (state)
            ST_IDLE: begin
                if (cmd_accept) begin
                    case (op)
                        OP_SET_X0:    vtx[0].x <= cmd_coord;
                        OP_SET_Y0:    vtx[0].y <= cmd_coord;
                        OP_SET_X1:    vtx[1].x <= cmd_coord;
                        OP_SET_Y1:    vtx[1].y <= cmd_coord;
                        OP_SET_X2:    vtx[2].x <= cmd_coord;
                        OP_SET_Y2:    vtx[2].y <= cmd_coord;
                        OP_SET_COLOR: fill_color <= cmd_color;
                        OP_CLEAR, OP_DRAW: begin
                            job_o.kind  <= (op == OP_CLEAR) ? JOB_CLEAR : JOB_TRIANGLE;
                            job_o.v     <= vtx;
                            job_o.color <= (op == OP_CLEAR) ? cmd_color : fill_color;
                            job_o.base  <= back_addr;
                            job_start_o <= 1'b1;
                            state       <= ST_RASTER;
                        end
                        OP_SWAP:      state <= ST_SWAP;
                        default:      ;
                    endcase
                end
            end

            ST_RASTER: begin
                // done is still high while the start pulse is in flight
                if (job_done_i && !job_start_o) begin
                    state <= ST_IDLE;
                end
            end

            ST_SWAP: begin
                if (swap_o) begin
                    state <= ST_IDLE;
                end
            end

            default: state <= ST_IDLE;
        endcase

        if (do_swap) begin
            swap_o       <= 1'b1;
            front_addr_o <= back_addr;
            back_addr    <= front_addr_o;
        end

        if (reset_i) begin
            state        <= ST_IDLE;
            job_start_o  <= 1'b0;
            swap_o       <= 1'b0;
            front_addr_o <= '0;
            back_addr    <= vram_addr_t'(`FB_SIZE);
        end
    end

endmodule

// File: source/gfx_cmd_pkg.sv
////////////////////////////////////////////////////////////////////////////
// command side types
// opcodes, vertices and the job handed to the rasterizer
////////////////////////////////////////////////////////////////////////////

`include "tri_raster_defines.svh"

package gfx_cmd_pkg;

    import gfx_pixel_pkg::*;

    typedef logic signed [`COORD_W-1:0] coord_t;

    // opcode sits in bits 31:24 of a command word
    typedef enum logic [`OPCODE_W-1:0] {
        OP_SET_X0    = 8'h00,
        OP_SET_Y0    = 8'h01,
        OP_SET_X1    = 8'h02,
        OP_SET_Y1    = 8'h03,
        OP_SET_X2    = 8'h04,
        OP_SET_Y2    = 8'h05,
        OP_SET_COLOR = 8'h06,
        OP_CLEAR     = 8'h07,
        OP_DRAW      = 8'h08,
        OP_SWAP      = 8'h09
    } opcode_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
    } vertex_t;

    typedef enum logic {
        JOB_CLEAR,
        JOB_TRIANGLE
    } raster_kind_t;

    typedef struct packed {
        raster_kind_t  kind;
        vertex_t [2:0] v;
        color_t        color;
        vram_addr_t    base;
    } raster_job_t;

endpackage

// File: source/gfx_pixel_pkg.sv
////////////////////////////////////////////////////////////////////////////
// pixel side types
// VRAM word addresses, pixel values and the pixel write record
////////////////////////////////////////////////////////////////////////////

`include "tri_raster_defines.svh"

package gfx_pixel_pkg;

    typedef logic [`ADDR_W-1:0] vram_addr_t;

    typedef logic [`COLOR_W-1:0] color_t;

    // one pending VRAM write
    typedef struct packed {
        vram_addr_t addr;
        color_t     color;
    } pixel_write_t;

endpackage

// File: source/pixel_fifo.sv
////////////////////////////////////////////////////////////////////////////
// pixel write FIFO
// circular buffer between the rasterizer and the VRAM writer
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "tri_raster_defines.svh"

module pixel_fifo
    import gfx_pixel_pkg::*;
(
    input  logic         clk,
    input  logic         reset_i,
    input  logic         push_i,
    input  pixel_write_t data_i,
    input  logic         pop_i,
    output logic         not_empty_o,
    output pixel_write_t data_o
);

    localparam int DEPTH = `PIX_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);

    pixel_write_t     mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;

    function automatic logic [PTR_W-1:0] next_ptr(logic [PTR_W-1:0] p);
        next_ptr = (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign not_empty_o = (count != '0);
    assign data_o      = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push_i) begin
            mem[wr_ptr] <= data_i;
        end
    end

    always_ff @(posedge clk) begin
        if (push_i) begin
            wr_ptr <= next_ptr(wr_ptr);
        end
        if (pop_i) begin
            rd_ptr <= next_ptr(rd_ptr);
        end

        case ({push_i, pop_i})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: ;
        endcase

        if (reset_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
    end

endmodule

// File: source/tri_raster_defines.svh
////////////////////////////////////////////////////////////////////////////
// triangle rasterizer build constants
// screen size, pixel buffer depth and field widths
////////////////////////////////////////////////////////////////////////////

`ifndef TRI_RASTER_DEFINES_SVH
`define TRI_RASTER_DEFINES_SVH

// screen size in pixels
`define FB_WIDTH 16
`define FB_HEIGHT 16
`define FB_SIZE (`FB_WIDTH * `FB_HEIGHT)

// pixel FIFO entries, also the rasterizer's starting credit count
`define PIX_FIFO_DEPTH 4

`define COORD_W 12
`define ADDR_W 32
`define COLOR_W 16
`define OPCODE_W 8

`endif

// File: source/tri_raster_top.sv
////////////////////////////////////////////////////////////////////////////
// triangle rasterizer top level
// command decoder, rasterizer, pixel FIFO and VRAM writer
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tri_raster_top
    import gfx_cmd_pkg::*, gfx_pixel_pkg::*;
(
    input  logic        clk,
    input  logic        reset_i,

    // command stream
    input  logic        cmd_valid_i,
    input  logic [31:0] cmd_data_i,
    output logic        cmd_ready_o,

    // display
    input  logic        vsync_i,
    output logic        swap_o,
    output vram_addr_t  front_addr_o,

    // VRAM write port
    output logic        vram_sel_o,
    output logic        vram_wr_o,
    output vram_addr_t  vram_addr_o,
    output color_t      vram_data_o,
    input  logic        vram_ack_i
);

    raster_job_t  job;
    logic         job_start;
    logic         job_done;
    logic         pix_push;
    pixel_write_t pix_in;
    logic         pix_pop;
    logic         pix_not_empty;
    pixel_write_t pix_head;
    logic         credit;

    cmd_decoder u_decoder (
        .clk          (clk),
        .reset_i      (reset_i),
        .cmd_valid_i  (cmd_valid_i),
        .cmd_data_i   (cmd_data_i),
        .cmd_ready_o  (cmd_ready_o),
        .vsync_i      (vsync_i),
        .swap_o       (swap_o),
        .front_addr_o (front_addr_o),
        .job_start_o  (job_start),
        .job_o        (job),
        .job_done_i   (job_done)
    );

    tri_rasterizer u_rasterizer (
        .clk         (clk),
        .reset_i     (reset_i),
        .job_start_i (job_start),
        .job_i       (job),
        .done_o      (job_done),
        .push_o      (pix_push),
        .pixel_o     (pix_in),
        .credit_i    (credit)
    );

    pixel_fifo u_fifo (
        .clk         (clk),
        .reset_i     (reset_i),
        .push_i      (pix_push),
        .data_i      (pix_in),
        .pop_i       (pix_pop),
        .not_empty_o (pix_not_empty),
        .data_o      (pix_head)
    );

    vram_writer u_writer (
        .clk         (clk),
        .reset_i     (reset_i),
        .not_empty_i (pix_not_empty),
        .data_i      (pix_head),
        .pop_o       (pix_pop),
        .credit_o    (credit),
        .vram_sel_o  (vram_sel_o),
        .vram_wr_o   (vram_wr_o),
        .vram_addr_o (vram_addr_o),
        .vram_data_o (vram_data_o),
        .vram_ack_i  (vram_ack_i)
    );

endmodule

// File: source/tri_rasterizer.sv
////////////////////////////////////////////////////////////////////////////
// triangle rasterizer
// scans the clipped bounding box, tests the three edge functions and
// pushes covered pixels into the write FIFO against credits
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "tri_raster_defines.svh"

module tri_rasterizer
    import gfx_cmd_pkg::*, gfx_pixel_pkg::*;
(
    input  logic         clk,
    input  logic         reset_i,
    input  logic         job_start_i,
    input  raster_job_t  job_i,
    output logic         done_o,
    output logic         push_o,
    output pixel_write_t pixel_o,
    input  logic         credit_i
);

    localparam int CRED_W = $clog2(`PIX_FIFO_DEPTH + 1);

    typedef enum logic [1:0] {
        RS_IDLE,
        RS_SETUP,
        RS_SCAN
    } rs_state_t;

    rs_state_t          state;
    raster_job_t        job;
    coord_t             x;
    coord_t             y;
    coord_t             min_x;
    coord_t             max_x;
    coord_t             max_y;
    coord_t             lo_x;
    coord_t             lo_y;
    coord_t             hi_x;
    coord_t             hi_y;
    logic [CRED_W-1:0]  credits;
    logic signed [31:0] e0;
    logic signed [31:0] e1;
    logic signed [31:0] e2;
    logic               covered;
    logic               has_credit;
    logic               step;

    function automatic coord_t min2(coord_t a, coord_t b);
        min2 = (a < b) ? a : b;
    endfunction

    function automatic coord_t max2(coord_t a, coord_t b);
        max2 = (a > b) ? a : b;
    endfunction

    // (p - a) x (b - a), positive when p lies left of a->b
    function automatic logic signed [31:0] edge_fn(vertex_t a, vertex_t b,
                                                   coord_t px, coord_t py);
        edge_fn = (32'(px) - 32'(a.x)) * (32'(b.y) - 32'(a.y))
                - (32'(py) - 32'(a.y)) * (32'(b.x) - 32'(a.x));
    endfunction

    // bounding box clipped to the screen, whole screen for a clear
    always_comb begin
        if (job.kind == JOB_CLEAR) begin
            lo_x = '0;
            lo_y = '0;
            hi_x = coord_t'(`FB_WIDTH - 1);
            hi_y = coord_t'(`FB_HEIGHT - 1);
        end else begin
            lo_x = max2(min2(min2(job.v[0].x, job.v[1].x), job.v[2].x), coord_t'(0));
            lo_y = max2(min2(min2(job.v[0].y, job.v[1].y), job.v[2].y), coord_t'(0));
            hi_x = min2(max2(max2(job.v[0].x, job.v[1].x), job.v[2].x),
                        coord_t'(`FB_WIDTH - 1));
            hi_y = min2(max2(max2(job.v[0].y, job.v[1].y), job.v[2].y),
                        coord_t'(`FB_HEIGHT - 1));
        end
    end

    // edge i is opposite vertex i
    assign e0 = edge_fn(job.v[1], job.v[2], x, y);
    assign e1 = edge_fn(job.v[2], job.v[0], x, y);
    assign e2 = edge_fn(job.v[0], job.v[1], x, y);

    assign covered    = (job.kind == JOB_CLEAR) || (e0 >= 0 && e1 >= 0 && e2 >= 0);
    assign has_credit = (credits != '0);

    // uncovered pixels never wait for a credit
    assign step   = (state == RS_SCAN) && (!covered || has_credit);
    assign push_o = (state == RS_SCAN) && covered && has_credit;

    assign pixel_o = '{
        addr:  job.base + vram_addr_t'(y) * `FB_WIDTH + vram_addr_t'(x),
        color: job.color
    };

    assign done_o = (state == RS_IDLE) && (credits == CRED_W'(`PIX_FIFO_DEPTH));

    always_ff @(posedge clk) begin
        case (state)
            RS_IDLE: begin
                if (job_start_i) begin
                    job   <= job_i;
                    state <= RS_SETUP;
                end
            end

            RS_SETUP: begin
                min_x <= lo_x;
                max_x <= hi_x;
                max_y <= hi_y;
                x     <= lo_x;
                y     <= lo_y;
                // a triangle fully off screen leaves an empty box
                state <= (lo_x > hi_x || lo_y > hi_y) ? RS_IDLE : RS_SCAN;
            end

            RS_SCAN: begin
                if (step) begin
                    if (x < max_x) begin
                        x <= x + coord_t'(1);
                    end else begin
                        x <= min_x;
                        if (y < max_y) begin
                            y <= y + coord_t'(1);
                        end else begin
                            state <= RS_IDLE;
                        end
                    end
                end
            end

            default: state <= RS_IDLE;
        endcase

        case ({push_o, credit_i})
            2'b10:   credits <= credits - 1'b1;
            2'b01:   credits <= credits + 1'b1;
            default: ;
        endcase

        if (reset_i) begin
            state   <= RS_IDLE;
            credits <= CRED_W'(`PIX_FIFO_DEPTH);
        end
    end

endmodule

// File: source/vram_writer.sv
////////////////////////////////////////////////////////////////////////////
// VRAM writer
// pops pixel writes, runs the select/ack cycle, returns one credit each
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module vram_writer
    import gfx_pixel_pkg::*;
(
    input  logic         clk,
    input  logic         reset_i,
    input  logic         not_empty_i,
    input  pixel_write_t data_i,
    output logic         pop_o,
    output logic         credit_o,
    output logic         vram_sel_o,
    output logic         vram_wr_o,
    output vram_addr_t   vram_addr_o,
    output color_t       vram_data_o,
    input  logic         vram_ack_i
);

    typedef enum logic {
        WR_IDLE,
        WR_ACCESS
    } wr_state_t;

    wr_state_t    state;
    pixel_write_t cur;

    assign pop_o = (state == WR_IDLE) && not_empty_i;

    // write-only port, strobes track the access state
    assign vram_sel_o  = (state == WR_ACCESS);
    assign vram_wr_o   = (state == WR_ACCESS);
    assign vram_addr_o = cur.addr;
    assign vram_data_o = cur.color;

    always_ff @(posedge clk) begin
        credit_o <= 1'b0;

        case (state)
            WR_IDLE: begin
                if (pop_o) begin
                    cur   <= data_i;
                    state <= WR_ACCESS;
                end
            end

            WR_ACCESS: begin
                if (vram_ack_i) begin
                    credit_o <= 1'b1;
                    state    <= WR_IDLE;
                end
            end

            default: state <= WR_IDLE;
        endcase

        if (reset_i) begin
            state    <= WR_IDLE;
            credit_o <= 1'b0;
        end
    end

endmodule

// File: tb/tri_raster_tb.sv
////////////////////////////////////////////////////////////////////////////
// testbench for the triangle rasterizer
// plays a command table and checks VRAM against a reference framebuffer
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "tri_raster_defines.svh"

module tri_raster_tb
    import gfx_cmd_pkg::*, gfx_pixel_pkg::*;
();

    localparam int FAST_ACK  = 2;
    localparam int SLOW_ACK  = 12;
    localparam int MEM_WORDS = 2 * `FB_SIZE;

    // expectation tags
    localparam logic [2:0] EXP_SET   = 3'd0;
    localparam logic [2:0] EXP_FB    = 3'd1;
    localparam logic [2:0] EXP_EMPTY = 3'd2;
    localparam logic [2:0] EXP_SWAP  = 3'd3;
    localparam logic [2:0] EXP_VSYNC = 3'd4;

    typedef struct packed {
        logic [31:0] word;
        logic [2:0]  tag;
        logic [7:0]  ack_max;
    } table_row_t;

    logic        clk;
    logic        reset_i;
    logic        cmd_valid_i;
    logic [31:0] cmd_data_i;
    logic        cmd_ready_o;
    logic        vsync_i;
    logic        swap_o;
    vram_addr_t  front_addr_o;
    logic        vram_sel;
    logic        vram_wr;
    vram_addr_t  vram_addr;
    color_t      vram_data;
    logic        vram_ack;
    logic [7:0]  ack_max;

    table_row_t  rows[$];
    color_t      ref_mem [MEM_WORDS];
    int          ref_x [3];
    int          ref_y [3];
    color_t      ref_color;
    vram_addr_t  ref_front;
    vram_addr_t  ref_back;
    int          checks = 0;
    int          mismatches = 0;
    int          write_count = 0;
    int          swap_count = 0;
    int          cycles = 0;
    int          cycle_limit = 1000000;

    tri_raster_top uut (
        .clk          (clk),
        .reset_i      (reset_i),
        .cmd_valid_i  (cmd_valid_i),
        .cmd_data_i   (cmd_data_i),
        .cmd_ready_o  (cmd_ready_o),
        .vsync_i      (vsync_i),
        .swap_o       (swap_o),
        .front_addr_o (front_addr_o),
        .vram_sel_o   (vram_sel),
        .vram_wr_o    (vram_wr),
        .vram_addr_o  (vram_addr),
        .vram_data_o  (vram_data),
        .vram_ack_i   (vram_ack)
    );

    vram_model #(.SEED(9485)) u_vram (
        .clk         (clk),
        .reset_i     (reset_i),
        .max_delay_i (ack_max),
        .sel_i       (vram_sel),
        .wr_i        (vram_wr),
        .addr_i      (vram_addr),
        .data_i      (vram_data),
        .ack_o       (vram_ack)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] cmd_word(opcode_t op, int arg);
        return {op, 24'(arg)};
    endfunction

    function automatic int edge_value(int ax, int ay, int bx, int by, int px, int py);
        return (px - ax) * (by - ay) - (py - ay) * (bx - ax);
    endfunction

    function automatic int min3(int a, int b, int c);
        return (a < b) ? ((a < c) ? a : c) : ((b < c) ? b : c);
    endfunction

    function automatic int max3(int a, int b, int c);
        return (a > b) ? ((a > c) ? a : c) : ((b > c) ? b : c);
    endfunction

    task automatic check_value(input logic [63:0] got, input logic [63:0] expected,
                               input string what);
        checks++;
        if (got !== expected) begin
            mismatches++;
            $display("mismatch at %0t ns: %s, got %0h expected %0h",
                     $time, what, got, expected);
        end
    endtask

    task automatic add_row(input logic [31:0] word, input logic [2:0] tag, input int ack);
        table_row_t r;
        r.word    = word;
        r.tag     = tag;
        r.ack_max = 8'(ack);
        rows.push_back(r);
    endtask

    task automatic add_vertex(input int idx, input int x, input int y, input int ack);
        add_row(cmd_word(opcode_t'(OP_SET_X0 + 2 * idx), x), EXP_SET, ack);
        add_row(cmd_word(opcode_t'(OP_SET_Y0 + 2 * idx), y), EXP_SET, ack);
    endtask

    task automatic build_table();
        add_row(cmd_word(OP_CLEAR, 16'h1111), EXP_FB, FAST_ACK);
        add_row(cmd_word(OP_SWAP, 0), EXP_SWAP, FAST_ACK);
        add_row(cmd_word(OP_CLEAR, 16'h2222), EXP_FB, FAST_ACK);
        // positive winding for the edge functions
        add_vertex(0, 2, 2, FAST_ACK);
        add_vertex(1, 2, 12, FAST_ACK);
        add_vertex(2, 12, 2, FAST_ACK);
        add_row(cmd_word(OP_SET_COLOR, 16'h07E0), EXP_SET, FAST_ACK);
        add_row(cmd_word(OP_DRAW, 0), EXP_FB, FAST_ACK);
        // same triangle wound the other way round
        add_vertex(1, 12, 2, FAST_ACK);
        add_vertex(2, 2, 12, FAST_ACK);
        add_row(cmd_word(OP_DRAW, 0), EXP_EMPTY, FAST_ACK);
        add_row(cmd_word(OP_SWAP, 1), EXP_VSYNC, FAST_ACK);
        add_row(cmd_word(OP_CLEAR, 16'h3333), EXP_FB, SLOW_ACK);
        // v0 sits above and left of the screen
        add_vertex(0, -4, -3, SLOW_ACK);
        add_vertex(1, 5, 14, SLOW_ACK);
        add_vertex(2, 14, 6, SLOW_ACK);
        add_row(cmd_word(OP_SET_COLOR, 16'hF800), EXP_SET, SLOW_ACK);
        add_row(cmd_word(OP_DRAW, 0), EXP_FB, SLOW_ACK);
        add_row(cmd_word(OP_SWAP, 0), EXP_SWAP, FAST_ACK);
    endtask

    task automatic track_set(input logic [31:0] word);
        case (opcode_t'(word[31:24]))
            OP_SET_X0:    ref_x[0] = $signed(word[11:0]);
            OP_SET_Y0:    ref_y[0] = $signed(word[11:0]);
            OP_SET_X1:    ref_x[1] = $signed(word[11:0]);
            OP_SET_Y1:    ref_y[1] = $signed(word[11:0]);
            OP_SET_X2:    ref_x[2] = $signed(word[11:0]);
            OP_SET_Y2:    ref_y[2] = $signed(word[11:0]);
            OP_SET_COLOR: ref_color = word[15:0];
            default:      ;
        endcase
    endtask

    // fills the reference back buffer and counts the pixels it wrote
    task automatic paint_reference(input logic whole, input color_t col, output int covered);
        int lx;
        int ly;
        int hx;
        int hy;
        int x;
        int y;
        int w0;
        int w1;
        int w2;
        covered = 0;
        lx = whole ? 0 : max3(min3(ref_x[0], ref_x[1], ref_x[2]), 0, 0);
        ly = whole ? 0 : max3(min3(ref_y[0], ref_y[1], ref_y[2]), 0, 0);
        hx = whole ? `FB_WIDTH - 1 :
                     min3(max3(ref_x[0], ref_x[1], ref_x[2]), `FB_WIDTH - 1, `FB_WIDTH - 1);
        hy = whole ? `FB_HEIGHT - 1 :
                     min3(max3(ref_y[0], ref_y[1], ref_y[2]), `FB_HEIGHT - 1, `FB_HEIGHT - 1);
        for (y = ly; y <= hy; y++) begin
            for (x = lx; x <= hx; x++) begin
                w0 = edge_value(ref_x[1], ref_y[1], ref_x[2], ref_y[2], x, y);
                w1 = edge_value(ref_x[2], ref_y[2], ref_x[0], ref_y[0], x, y);
                w2 = edge_value(ref_x[0], ref_y[0], ref_x[1], ref_y[1], x, y);
                if (whole || (w0 >= 0 && w1 >= 0 && w2 >= 0)) begin
                    ref_mem[ref_back + y * `FB_WIDTH + x] = col;
                    covered++;
                end
            end
        end
    endtask

    task automatic compare_memory(input string what);
        int i;
        for (i = 0; i < MEM_WORDS; i++) begin
            check_value(u_vram.mem[i], ref_mem[i], $sformatf("%s, word %0d", what, i));
        end
    endtask

    task automatic swap_reference();
        vram_addr_t tmp;
        tmp       = ref_front;
        ref_front = ref_back;
        ref_back  = tmp;
    endtask

    task automatic issue_cmd(input logic [31:0] word);
        cmd_valid_i <= 1'b1;
        cmd_data_i  <= word;
        @(posedge clk);
        while (!cmd_ready_o) @(posedge clk);
        cmd_valid_i <= 1'b0;
    endtask

    task automatic wait_ready();
        @(posedge clk);
        while (!cmd_ready_o) @(posedge clk);
    endtask

    // VRAM write and swap pulse monitor
    always @(posedge clk) begin
        if (vram_sel && vram_wr && vram_ack) begin
            write_count++;
            check_value(vram_addr >= ref_back && vram_addr < ref_back + `FB_SIZE, 1'b1,
                        $sformatf("write at %0d inside back buffer", vram_addr));
        end
        if (swap_o) begin
            swap_count++;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("timeout: no result after %0d cycles", cycles);
            $display("Test failed");
            $finish;
        end
    end

    initial begin
        table_row_t row;
        opcode_t    op;
        int         covered;
        int         base_writes;
        int         base_swaps;
        int         i;

        reset_i     = 1'b1;
        cmd_valid_i = 1'b0;
        cmd_data_i  = '0;
        vsync_i     = 1'b0;
        ack_max     = 8'(FAST_ACK);
        build_table();
        cycle_limit = (rows.size() + 1) * `FB_SIZE * (SLOW_ACK + 4);
        for (i = 0; i < MEM_WORDS; i++) begin
            ref_mem[i] = color_t'(i) ^ 16'hA5C3;
        end
        ref_front = '0;
        ref_back  = vram_addr_t'(`FB_SIZE);

        repeat (4) @(posedge clk);
        reset_i <= 1'b0;
        @(posedge clk);
        check_value(cmd_ready_o, 1'b1, "ready after reset");
        check_value({vram_sel, vram_wr, swap_o}, 3'b000, "strobes after reset");
        check_value(front_addr_o, 0, "front address after reset");

        foreach (rows[n]) begin
            row         = rows[n];
            op          = opcode_t'(row.word[31:24]);
            ack_max    <= row.ack_max;
            base_writes = write_count;
            base_swaps  = swap_count;
            issue_cmd(row.word);
            case (row.tag)
                EXP_SET: begin
                    track_set(row.word);
                    wait_ready();
                end
                EXP_FB, EXP_EMPTY: begin
                    wait_ready();
                    paint_reference(op == OP_CLEAR,
                                    (op == OP_CLEAR) ? color_t'(row.word[15:0]) : ref_color,
                                    covered);
                    check_value(write_count - base_writes, covered, "writes in one job");
                    if (row.tag == EXP_EMPTY) begin
                        check_value(write_count - base_writes, 0, "writes of a clockwise draw");
                    end
                    compare_memory($sformatf("memory after row %0d", n));
                end
                EXP_SWAP: begin
                    wait_ready();
                    swap_reference();
                    check_value(front_addr_o, ref_front, "front address after swap");
                    check_value(swap_count - base_swaps, 1, "swap pulses");
                end
                EXP_VSYNC: begin
                    repeat (6) @(posedge clk);
                    check_value(swap_count - base_swaps, 0, "swap pulses before vsync");
                    check_value(front_addr_o, ref_front, "front address before vsync");
                    vsync_i <= 1'b1;
                    wait_ready();
                    vsync_i <= 1'b0;
                    swap_reference();
                    check_value(front_addr_o, ref_front, "front address after vsync swap");
                    check_value(swap_count - base_swaps, 1, "swap pulses after vsync");
                end
                default: ;
            endcase
        end

        $display("checks run: %0d, mismatches: %0d", checks, mismatches);
        if (mismatches == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: tb/vram_model.sv
////////////////////////////////////////////////////////////////////////////
// behavioral VRAM
// write-only word memory that answers each access after a random delay
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "tri_raster_defines.svh"

module vram_model
    import gfx_pixel_pkg::*;
#(
    parameter int SEED = 1
)
(
    input  logic       clk,
    input  logic       reset_i,
    input  logic [7:0] max_delay_i,
    input  logic       sel_i,
    input  logic       wr_i,
    input  vram_addr_t addr_i,
    input  color_t     data_i,
    output logic       ack_o
);

    localparam int WORDS = 2 * `FB_SIZE;

    color_t     mem [WORDS];
    integer     seed;
    logic       busy;
    logic [7:0] wait_cnt;

    initial begin
        int i;
        seed  = SEED;
        ack_o = 1'b0;
        busy  = 1'b0;
        // every word starts distinct so a missing or stray write shows up
        for (i = 0; i < WORDS; i++) begin
            mem[i] = color_t'(i) ^ 16'hA5C3;
        end
    end

    always @(posedge clk) begin
        ack_o <= 1'b0;
        if (reset_i) begin
            busy <= 1'b0;
        end else if (sel_i && wr_i && !ack_o) begin
            if (!busy) begin
                busy     <= 1'b1;
                wait_cnt <= 8'($unsigned($random(seed)) % (max_delay_i + 1));
            end else if (wait_cnt == 0) begin
                ack_o <= 1'b1;
                busy  <= 1'b0;
                if (addr_i < WORDS) begin
                    mem[addr_i] <= data_i;
                end
            end else begin
                wait_cnt <= wait_cnt - 1'b1;
            end
        end
    end

endmodule

// File: tri_raster.f
+incdir+source
source/gfx_pixel_pkg.sv
source/gfx_cmd_pkg.sv
source/cmd_decoder.sv
source/tri_rasterizer.sv
source/pixel_fifo.sv
source/vram_writer.sv
source/tri_raster_top.sv
tb/vram_model.sv
tb/tri_raster_tb.sv
